//--- Bender.yml
package:
  name: xeng

export_include_dirs:
  - include

sources:
  - src/xeng_pkg.sv
  - src/xeng_host_if.sv
  - src/xeng_host_decode.sv
  - src/xeng_mem.sv
  - src/xeng_alu.sv
  - src/xeng_mul.sv
  - src/xeng_read_mux.sv
  - src/xeng_top.sv
  - target: test
    files:
      - bench/xeng_tb.sv

//--- bench/xeng_tb.sv
`include "xeng_config.svh"

module xeng_tb;

   localparam int DW           = `XENG_DATA_W;
   localparam int WORDS        = 2**`XENG_MEM_ADDR_W;
   localparam int POLL_MAX     = 200;
   localparam int HOST_CYCLES  = 300;
   localparam int RUN_CYCLES   = 340;
   localparam int N_RUNS       = 14;
   localparam int WATCH_CYCLES = HOST_CYCLES + N_RUNS * RUN_CYCLES + 200;

   // rst is the clock and clk the reset of this design
   logic                          rst;
   logic                          clk;
   logic                          ctr_valid;
   logic                          ctr_we;
   logic [`XENG_CTR_ADDR_W-1:0]   ctr_addr;
   logic [DW-1:0]                 ctr_wdata;
   logic                          data_valid;
   logic                          data_we;
   logic [`XENG_DATA_ADDR_W-1:0]  data_addr;
   logic [DW-1:0]                 data_wdata;
   xeng_pkg::engine_cfg_t         config_bus;
   logic [DW-1:0]                 ctr_rdata;
   logic [DW-1:0]                 data_rdata;

   logic [DW-1:0] model_mem [2][WORDS];
   integer        seed;
   int            errors;
   int            checks;
   int            test_errors;

   xeng_top dut0 (
      .rst(rst), .clk(clk),
      .ctr_valid(ctr_valid), .ctr_we(ctr_we),
      .ctr_addr(ctr_addr), .ctr_wdata(ctr_wdata),
      .data_valid(data_valid), .data_we(data_we),
      .data_addr(data_addr), .data_wdata(data_wdata),
      .config_bus(config_bus),
      .ctr_rdata(ctr_rdata), .data_rdata(data_rdata)
   );

   always #10 rst = ~rst;

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   function automatic logic [DW-1:0] pick(input xeng_pkg::bus_t b, input logic [3:0] sel);
      logic [DW-1:0] w;
      w = '0;
      if (sel < `XENG_BUS_N) begin
         w = b[sel];
      end
      return w;
   endfunction

   function automatic logic [DW-1:0] alu_ref(input xeng_pkg::alu_op_t op,
                                             input logic [DW-1:0] a,
                                             input logic [DW-1:0] b);
      logic [DW-1:0] r;
      case (op)
         xeng_pkg::ALU_ADD: r = a + b;
         xeng_pkg::ALU_SUB: r = a - b;
         xeng_pkg::ALU_AND: r = a & b;
         xeng_pkg::ALU_OR:  r = a | b;
         xeng_pkg::ALU_XOR: r = a ^ b;
         xeng_pkg::ALU_MAX: r = (a > b) ? a : b;
         xeng_pkg::ALU_MIN: r = (a < b) ? a : b;
         default:           r = a;
      endcase
      return r;
   endfunction

   function automatic xeng_pkg::mem_port_cfg_t port_cfg(input logic we, input logic [3:0] sel,
                                                        input int start, input int incr,
                                                        input int iter, input int delay);
      xeng_pkg::mem_port_cfg_t pc;
      pc       = '0;
      pc.en    = 1'b1;
      pc.we    = we;
      pc.sel   = sel;
      pc.start = 6'(start);
      pc.incr  = 6'(incr);
      pc.iter  = 7'(iter);
      pc.delay = 4'(delay);
      return pc;
   endfunction

   task automatic check_word(input string what, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input int num, input string name);
      $display("test %0d %s: %0d errors", num, name, errors - test_errors);
      test_errors = errors;
   endtask

   // one cycle on both channels, returns on the next falling edge
   task automatic host_access(input logic cv, input logic cw,
                              input logic [`XENG_CTR_ADDR_W-1:0] ca, input logic [DW-1:0] cd,
                              input logic dv, input logic dw,
                              input logic [`XENG_DATA_ADDR_W-1:0] da, input logic [DW-1:0] dd);
      ctr_valid  = cv;
      ctr_we     = cw;
      ctr_addr   = ca;
      ctr_wdata  = cd;
      data_valid = dv;
      data_we    = dw;
      data_addr  = da;
      data_wdata = dd;
      @(negedge rst);
      ctr_valid  = 1'b0;
      data_valid = 1'b0;
   endtask

   // status is combinational, sampled mid cycle
   task automatic read_status(output logic [DW-1:0] st);
      ctr_valid = 1'b1;
      ctr_we    = 1'b0;
      ctr_addr  = 8'h80;
      #5;
      st = ctr_rdata;
      @(negedge rst);
      ctr_valid = 1'b0;
   endtask

   task automatic check_mems();
      for (int w = 0; w < WORDS; w++) begin
         for (int m = 0; m < 2; m++) begin
            host_access(1'b1, 1'b0, {1'b0, 1'(m), 6'(w)}, '0,
                        1'b1, 1'b0, {1'(1 - m), 6'(w)}, '0);
            check_word($sformatf("ctr read mem%0d[%0d]", m, w), ctr_rdata, model_mem[m][w]);
            check_word($sformatf("data read mem%0d[%0d]", 1 - m, w), data_rdata,
                       model_mem[1 - m][w]);
         end
      end
   endtask

   // cycle t counts from the cycle after the run register
   task automatic model_run(input xeng_pkg::engine_cfg_t c);
      xeng_pkg::bus_t         mb;
      logic [3:0][DW-1:0]     rd;
      logic [3:0][DW-1:0]     nrd;
      logic [1:0][DW-1:0]     alu_q;
      logic [DW-1:0]          mul_q;
      logic [2*DW-1:0]        prod;
      logic [3:0][5:0]        addr;
      logic [3:0]             acc;
      int                     last;
      int                     k;
      last  = 0;
      rd    = '0;
      alu_q = '0;
      mul_q = '0;
      for (int p = 0; p < 4; p++) begin
         if (c.mem[p].en && int'(c.mem[p].delay) + int'(c.mem[p].iter) > last) begin
            last = int'(c.mem[p].delay) + int'(c.mem[p].iter);
         end
      end
      for (int t = 1; t <= last; t++) begin
         mb = '0;
         mb[`XENG_SRC_ONE] = DW'(1);
         for (int p = 0; p < 4; p++) begin
            mb[`XENG_SRC_MEM0A + p] = rd[p];
         end
         mb[`XENG_SRC_ALU0] = alu_q[0];
         mb[`XENG_SRC_ALU1] = alu_q[1];
         mb[`XENG_SRC_MUL0] = mul_q;
         // reads see the memory before this cycle's writes
         for (int p = 0; p < 4; p++) begin
            k       = t - 1 - int'(c.mem[p].delay);
            acc[p]  = c.mem[p].en && k >= 0 && k < int'(c.mem[p].iter);
            addr[p] = 6'(int'(c.mem[p].start) + k * int'(c.mem[p].incr));
            nrd[p]  = rd[p];
            if (acc[p] && !c.mem[p].we) begin
               nrd[p] = model_mem[p / 2][addr[p]];
            end
         end
         // port B after port A of the same memory
         for (int p = 0; p < 4; p++) begin
            if (acc[p] && c.mem[p].we) begin
               model_mem[p / 2][addr[p]] = pick(mb, c.mem[p].sel);
            end
         end
         rd = nrd;
         for (int i = 0; i < 2; i++) begin
            alu_q[i] = alu_ref(c.alu[i].op, pick(mb, c.alu[i].sel_a), pick(mb, c.alu[i].sel_b));
         end
         prod  = pick(mb, c.mul[0].sel_a) * pick(mb, c.mul[0].sel_b);
         mul_q = prod[DW-1:0];
      end
   endtask

   task automatic run_engine(input xeng_pkg::engine_cfg_t c, input bit scramble);
      logic [DW-1:0] st;
      logic [159:0]  noise;
      int            polls;
      config_bus = c;
      host_access(1'b1, 1'b1, 8'h80, DW'(1), 1'b0, 1'b0, '0, '0);
      model_run(c);
      read_status(st);
      check_word("status right after run", st, DW'(0));
      polls = 0;
      while (st !== DW'(1) && polls < POLL_MAX) begin
         if (scramble) begin
            noise = {rand_word(), rand_word(), rand_word(), rand_word(), rand_word()};
            config_bus = noise[$bits(xeng_pkg::engine_cfg_t)-1:0];
         end
         read_status(st);
         polls++;
      end
      checks++;
      assert (st === DW'(1)) else begin
         $display("status bit did not return to 1 within %0d cycles of a run", POLL_MAX);
         errors++;
      end
      check_mems();
   endtask

   initial begin
      #(WATCH_CYCLES * 20);
      $display("watchdog expired after %0d cycles before the tests completed", WATCH_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      xeng_pkg::engine_cfg_t         c;
      logic [DW-1:0]                 st;
      logic [DW-1:0]                 cd;
      logic [DW-1:0]                 dd;
      logic [`XENG_CTR_ADDR_W-1:0]   ca;
      logic [`XENG_DATA_ADDR_W-1:0]  da;
      int                            n;
      int                            d;
      int                            s;
      int                            inc;
      seed        = 45;
      errors      = 0;
      checks      = 0;
      test_errors = 0;
      rst         = 1'b0;
      clk         = 1'b1;
      ctr_valid   = 1'b0;
      ctr_we      = 1'b0;
      ctr_addr    = '0;
      ctr_wdata   = '0;
      data_valid  = 1'b0;
      data_we     = 1'b0;
      data_addr   = '0;
      data_wdata  = '0;
      config_bus  = '0;
      repeat (5) @(negedge rst);
      clk = 1'b0;
      @(negedge rst);

      // host writes, filling both memories first
      read_status(st);
      check_word("status after reset", st, DW'(1));
      for (int w = 0; w < WORDS; w++) begin
         cd = DW'(rand_word());
         dd = DW'(rand_word());
         host_access(1'b1, 1'b1, {2'b00, 6'(w)}, cd, 1'b1, 1'b1, {1'b1, 6'(w)}, dd);
         model_mem[0][w] = cd;
         model_mem[1][w] = dd;
      end
      repeat (100) begin
         ca = {1'b0, 7'(rand_word())};
         da = 7'(rand_word());
         cd = DW'(rand_word());
         dd = DW'(rand_word());
         host_access(1'b1, 1'b1, ca, cd, 1'b1, 1'b1, da, dd);
         model_mem[ca[6]][ca[5:0]] = cd;
         model_mem[da[6]][da[5:0]] = dd;
      end
      check_mems();
      report_test(1, "host access");

      repeat (2) begin
         n = 1 + rand_word() % 64;
         d = rand_word() % 15;
         c = '0;
         c.mem[0] = port_cfg(1'b0, '0, rand_word() % 64, rand_word() % 64, n, d);
         c.mem[3] = port_cfg(1'b1, `XENG_SRC_MEM0A, rand_word() % 64, rand_word() % 64,
                             n, d + 1);
         run_engine(c, 1'b0);
      end
      report_test(2, "copy");

      for (int op = 0; op < 8; op++) begin
         n = 1 + rand_word() % 64;
         c = '0;
         c.mem[0] = port_cfg(1'b0, '0, rand_word() % 64, rand_word() % 64, n, 0);
         c.mem[2] = port_cfg(1'b0, '0, rand_word() % 64, rand_word() % 64, n, 0);
         c.alu[0].op    = xeng_pkg::alu_op_t'(op);
         c.alu[0].sel_a = `XENG_SRC_MEM0A;
         c.alu[0].sel_b = `XENG_SRC_MEM0A + 2;
         c.mem[3] = port_cfg(1'b1, `XENG_SRC_ALU0, rand_word() % 64, rand_word() % 64, n, 2);
         run_engine(c, 1'b0);
      end
      report_test(3, "alu");

      repeat (2) begin
         n = 1 + rand_word() % 64;
         c = '0;
         c.mem[0] = port_cfg(1'b0, '0, rand_word() % 64, rand_word() % 64, n, 0);
         c.mem[2] = port_cfg(1'b0, '0, rand_word() % 64, rand_word() % 64, n, 0);
         c.mul[0].sel_a = `XENG_SRC_MEM0A;
         c.mul[0].sel_b = `XENG_SRC_MEM0A + 2;
         c.mem[1] = port_cfg(1'b1, `XENG_SRC_MUL0, rand_word() % 64, rand_word() % 64, n, 2);
         run_engine(c, 1'b0);
      end
      report_test(4, "multiplier");

      // config_bus is noise for the whole run
      n = 1 + rand_word() % 64;
      d = rand_word() % 15;
      c = '0;
      c.mem[2] = port_cfg(1'b0, '0, rand_word() % 64, rand_word() % 64, n, d);
      c.mem[1] = port_cfg(1'b1, `XENG_SRC_MEM0A + 2, rand_word() % 64, rand_word() % 64,
                          n, d + 1);
      run_engine(c, 1'b1);
      report_test(5, "shadow hold");

      // both mem0 ports hit the same addresses in the same cycles
      n   = 1 + rand_word() % 64;
      s   = rand_word() % 64;
      inc = rand_word() % 64;
      c = '0;
      c.mem[2] = port_cfg(1'b0, '0, rand_word() % 64, rand_word() % 64, n, 0);
      c.mem[0] = port_cfg(1'b1, `XENG_SRC_ONE, s, inc, n, 1);
      c.mem[1] = port_cfg(1'b1, `XENG_SRC_MEM0A + 2, s, inc, n, 1);
      run_engine(c, 1'b0);
      report_test(6, "same address write");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- include/xeng_config.svh
`ifndef XENG_CONFIG_SVH
`define XENG_CONFIG_SVH

// data path
`define XENG_DATA_W       16
`define XENG_MEM_ADDR_W   6
`define XENG_DELAY_W      4

// unit counts
`define XENG_N_MEM        2
`define XENG_N_ALU        2
`define XENG_N_MUL        1
`define XENG_MEM_SEL_W    1

// host channel address widths: ctl bit, memory select, word
`define XENG_CTR_ADDR_W   8
`define XENG_DATA_ADDR_W  7

// bus source selection
`define XENG_SEL_W        4
`define XENG_BUS_N        9

// bus source indices, memory m port p sits at MEM0A + 2m + p
`define XENG_SRC_ZERO     0
`define XENG_SRC_ONE      1
`define XENG_SRC_MEM0A    2
`define XENG_SRC_ALU0     6
`define XENG_SRC_ALU1     7
`define XENG_SRC_MUL0     8

`endif

//--- src/xeng_alu.sv
`include "xeng_config.svh"

module xeng_alu (
   input  logic                     rst,
   input  logic                     clk,
   input  logic                     run_start,
   input  xeng_pkg::alu_cfg_t       cfg,
   input  xeng_pkg::bus_t           bus,
   output logic [`XENG_DATA_W-1:0]  out
);

   logic [`XENG_DATA_W-1:0] op_a;
   logic [`XENG_DATA_W-1:0] op_b;
   logic [`XENG_DATA_W-1:0] res;

   assign op_a = xeng_pkg::bus_pick(bus, cfg.sel_a);
   assign op_b = xeng_pkg::bus_pick(bus, cfg.sel_b);

   // max and min compare unsigned
   always_comb begin
      case (cfg.op)
         xeng_pkg::ALU_ADD:    res = op_a + op_b;
         xeng_pkg::ALU_SUB:    res = op_a - op_b;
         xeng_pkg::ALU_AND:    res = op_a & op_b;
         xeng_pkg::ALU_OR:     res = op_a | op_b;
         xeng_pkg::ALU_XOR:    res = op_a ^ op_b;
         xeng_pkg::ALU_MAX:    res = (op_a > op_b) ? op_a : op_b;
         xeng_pkg::ALU_MIN:    res = (op_a < op_b) ? op_a : op_b;
         default:              res = op_a;
      endcase
   end

   // one cycle behind the operands on the bus
   always_ff @(posedge rst, posedge clk) begin
      if (clk) begin
         out <= '0;
      end else if (run_start) begin
         out <= '0;
      end else begin
         out <= res;
      end
   end

endmodule

//--- src/xeng_host_decode.sv
`include "xeng_config.svh"

module xeng_host_decode (
   input  logic                          rst,
   input  logic                          clk,
   input  logic                          ctr_valid,
   input  logic                          ctr_we,
   input  logic [`XENG_CTR_ADDR_W-1:0]   ctr_addr,
   input  logic [`XENG_DATA_W-1:0]       ctr_wdata,
   input  logic                          data_valid,
   input  logic                          data_we,
   input  logic [`XENG_DATA_ADDR_W-1:0]  data_addr,
   input  logic [`XENG_DATA_W-1:0]       data_wdata,
   input  xeng_pkg::engine_cfg_t         config_bus,
   xeng_host_if.decoder                  ctr_mem [`XENG_N_MEM],
   xeng_host_if.decoder                  dat_mem [`XENG_N_MEM],
   output logic                          run_start,
   output xeng_pkg::engine_cfg_t         cfg,
   output logic                          ctr_is_status,
   output logic [`XENG_MEM_SEL_W-1:0]    rd_ctr_mem,
   output logic [`XENG_MEM_SEL_W-1:0]    rd_dat_mem
);

   localparam int SW = `XENG_MEM_SEL_W;

   logic          ctr_ctl;
   logic [SW-1:0] ctr_sel;
   logic [SW-1:0] dat_sel;
   logic          run;

   // bit 7 picks the control register, bit 6 the memory
   assign ctr_ctl = ctr_addr[`XENG_CTR_ADDR_W-1];
   assign ctr_sel = ctr_addr[`XENG_MEM_ADDR_W +: SW];
   assign dat_sel = data_addr[`XENG_MEM_ADDR_W +: SW];

   assign run = ctr_valid & ctr_we & ctr_ctl & ctr_wdata[0];
   assign ctr_is_status = ctr_valid & ~ctr_we & ctr_ctl;

   // per memory strobes, ctr to port A and data to port B
   for (genvar m = 0; m < `XENG_N_MEM; m++) begin : g_mem
      assign ctr_mem[m].valid = ctr_valid & ~ctr_ctl & (ctr_sel == SW'(m));
      assign ctr_mem[m].we    = ctr_we;
      assign ctr_mem[m].addr  = ctr_addr[`XENG_MEM_ADDR_W-1:0];
      assign ctr_mem[m].wdata = ctr_wdata;

      assign dat_mem[m].valid = data_valid & (dat_sel == SW'(m));
      assign dat_mem[m].we    = data_we;
      assign dat_mem[m].addr  = data_addr[`XENG_MEM_ADDR_W-1:0];
      assign dat_mem[m].wdata = data_wdata;
   end

   // run register is high for one cycle, shadow holds for the whole run
   always_ff @(posedge rst, posedge clk) begin
      if (clk) begin
         run_start <= 1'b0;
         cfg       <= '0;
      end else begin
         run_start <= run;
         if (run) begin
            cfg <= config_bus;
         end
      end
   end

   // memory selects for the read muxes, updated on reads only
   always_ff @(posedge rst, posedge clk) begin
      if (clk) begin
         rd_ctr_mem <= '0;
         rd_dat_mem <= '0;
      end else begin
         if (ctr_valid && !ctr_we && !ctr_ctl) begin
            rd_ctr_mem <= ctr_sel;
         end
         if (data_valid && !data_we) begin
            rd_dat_mem <= dat_sel;
         end
      end
   end

endmodule

//--- src/xeng_host_if.sv
`include "xeng_config.svh"

// one host access channel toward one memory port
interface xeng_host_if;

   logic                         valid;
   logic                         we;
   logic [`XENG_MEM_ADDR_W-1:0]  addr;
   logic [`XENG_DATA_W-1:0]      wdata;

   modport decoder (
      output valid, we, addr, wdata
   );

   modport mem (
      input valid, we, addr, wdata
   );

endinterface

//--- src/xeng_mem.sv
`include "xeng_config.svh"

module xeng_mem (
   input  logic                      rst,
   input  logic                      clk,
   xeng_host_if.mem                  ctr_port,
   xeng_host_if.mem                  dat_port,
   input  logic                      run_start,
   input  xeng_pkg::mem_port_cfg_t   cfg_a,
   input  xeng_pkg::mem_port_cfg_t   cfg_b,
   input  xeng_pkg::bus_t            bus,
   output logic [`XENG_DATA_W-1:0]   out_a,
   output logic [`XENG_DATA_W-1:0]   out_b,
   output logic                      done_a,
   output logic                      done_b
);

   localparam int AW = `XENG_MEM_ADDR_W;
   localparam int DW = `XENG_DATA_W;

   xeng_pkg::mem_port_cfg_t pcfg [2];

   logic [DW-1:0]              ram [2**AW];
   logic [1:0]                 busy;
   logic [1:0]                 done_q;
   logic [1:0]                 acc;
   logic [`XENG_DELAY_W-1:0]   dly [2];
   logic [AW-1:0]              gen_addr [2];
   logic [AW:0]                cnt [2];

   logic [1:0]                 host_valid;
   logic [1:0]                 host_we;
   logic [AW-1:0]              host_addr [2];
   logic [DW-1:0]              host_wdata [2];
   logic [1:0]                 port_en;
   logic [1:0]                 port_we;
   logic [AW-1:0]              port_addr [2];
   logic [DW-1:0]              port_wdata [2];
   logic [DW-1:0]              rdata [2];

   // index 0 is port A, index 1 is port B
   assign pcfg[0]       = cfg_a;
   assign pcfg[1]       = cfg_b;
   assign host_valid    = {dat_port.valid, ctr_port.valid};
   assign host_we       = {dat_port.we, ctr_port.we};
   assign host_addr[0]  = ctr_port.addr;
   assign host_addr[1]  = dat_port.addr;
   assign host_wdata[0] = ctr_port.wdata;
   assign host_wdata[1] = dat_port.wdata;

   // generator owns the port while it accesses, host otherwise
   always_comb begin
      for (int p = 0; p < 2; p++) begin
         acc[p] = busy[p] & (dly[p] == '0);
         if (acc[p]) begin
            port_en[p]    = 1'b1;
            port_we[p]    = pcfg[p].we;
            port_addr[p]  = gen_addr[p];
            port_wdata[p] = xeng_pkg::bus_pick(bus, pcfg[p].sel);
         end else begin
            port_en[p]    = host_valid[p];
            port_we[p]    = host_we[p];
            port_addr[p]  = host_addr[p];
            port_wdata[p] = host_wdata[p];
         end
      end
   end

   // address generators: delay, then iter accesses stepping by incr
   always_ff @(posedge rst, posedge clk) begin
      if (clk) begin
         busy   <= '0;
         done_q <= '1;
         for (int p = 0; p < 2; p++) begin
            dly[p]      <= '0;
            gen_addr[p] <= '0;
            cnt[p]      <= '0;
         end
      end else begin
         for (int p = 0; p < 2; p++) begin
            if (run_start) begin
               busy[p]     <= pcfg[p].en && (pcfg[p].iter != '0);
               done_q[p]   <= !(pcfg[p].en && (pcfg[p].iter != '0));
               dly[p]      <= pcfg[p].delay;
               gen_addr[p] <= pcfg[p].start;
               cnt[p]      <= pcfg[p].iter;
            end else if (busy[p]) begin
               if (dly[p] != '0) begin
                  dly[p] <= dly[p] - 1'b1;
               end else begin
                  gen_addr[p] <= gen_addr[p] + pcfg[p].incr;
                  cnt[p]      <= cnt[p] - 1'b1;
                  if (cnt[p] == 1) begin
                     busy[p]   <= 1'b0;
                     done_q[p] <= 1'b1;
                  end
               end
            end
         end
      end
   end

   // port B comes last so it wins a same address write
   always_ff @(posedge rst) begin
      for (int p = 0; p < 2; p++) begin
         if (port_en[p] && port_we[p]) begin
            ram[port_addr[p]] <= port_wdata[p];
         end
         if (port_en[p] && !port_we[p]) begin
            rdata[p] <= ram[port_addr[p]];
         end
      end
   end

   assign out_a = rdata[0];
   assign out_b = rdata[1];

   // flags already read as cleared while the run register is high
   assign done_a = done_q[0] & ~run_start;
   assign done_b = done_q[1] & ~run_start;

endmodule

//--- src/xeng_mul.sv
`include "xeng_config.svh"

module xeng_mul (
   input  logic                     rst,
   input  logic                     clk,
   input  logic                     run_start,
   input  xeng_pkg::mul_cfg_t       cfg,
   input  xeng_pkg::bus_t           bus,
   output logic [`XENG_DATA_W-1:0]  out
);

   logic [`XENG_DATA_W-1:0]   op_a;
   logic [`XENG_DATA_W-1:0]   op_b;
   logic [2*`XENG_DATA_W-1:0] prod;

   assign op_a = xeng_pkg::bus_pick(bus, cfg.sel_a);
   assign op_b = xeng_pkg::bus_pick(bus, cfg.sel_b);
   assign prod = op_a * op_b;

   // only the low half goes back on the bus
   always_ff @(posedge rst, posedge clk) begin
      if (clk) begin
         out <= '0;
      end else if (run_start) begin
         out <= '0;
      end else begin
         out <= prod[`XENG_DATA_W-1:0];
      end
   end

endmodule

//--- src/xeng_pkg.sv
`include "xeng_config.svh"

package xeng_pkg;

   // one word per bus source
   typedef logic [`XENG_BUS_N-1:0][`XENG_DATA_W-1:0] bus_t;

   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_AND    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_XOR    = 3'd4,
      ALU_MAX    = 3'd5,
      ALU_MIN    = 3'd6,
      ALU_PASS_A = 3'd7
   } alu_op_t;

   // spare bit pads the port word to 30 bits
   typedef struct packed {
      logic                         spare;
      logic                         en;
      logic                         we;
      logic [`XENG_SEL_W-1:0]       sel;
      logic [`XENG_MEM_ADDR_W-1:0]  start;
      logic [`XENG_MEM_ADDR_W-1:0]  incr;
      logic [`XENG_MEM_ADDR_W:0]    iter;
      logic [`XENG_DELAY_W-1:0]     delay;
   } mem_port_cfg_t;

   typedef struct packed {
      alu_op_t                op;
      logic [`XENG_SEL_W-1:0] sel_a;
      logic [`XENG_SEL_W-1:0] sel_b;
   } alu_cfg_t;

   typedef struct packed {
      logic [`XENG_SEL_W-1:0] sel_a;
      logic [`XENG_SEL_W-1:0] sel_b;
   } mul_cfg_t;

   // port index is 2*mem + port
   typedef struct packed {
      mem_port_cfg_t [2*`XENG_N_MEM-1:0] mem;
      alu_cfg_t [`XENG_N_ALU-1:0]        alu;
      mul_cfg_t [`XENG_N_MUL-1:0]        mul;
   } engine_cfg_t;

   // out of range selectors read as zero
   function automatic logic [`XENG_DATA_W-1:0] bus_pick(bus_t bus,
                                                        logic [`XENG_SEL_W-1:0] sel);
      logic [`XENG_DATA_W-1:0] word;
      word = '0;
      if (sel < `XENG_BUS_N) begin
         word = bus[sel];
      end
      return word;
   endfunction

endpackage

//--- src/xeng_read_mux.sv
`include "xeng_config.svh"

module xeng_read_mux (
   input  logic                                      ctr_is_status,
   input  logic [`XENG_MEM_SEL_W-1:0]                rd_ctr_mem,
   input  logic [`XENG_MEM_SEL_W-1:0]                rd_dat_mem,
   input  logic [`XENG_N_MEM-1:0][`XENG_DATA_W-1:0]  mem_a,
   input  logic [`XENG_N_MEM-1:0][`XENG_DATA_W-1:0]  mem_b,
   input  logic [2*`XENG_N_MEM-1:0]                  done,
   output logic [`XENG_DATA_W-1:0]                   ctr_rdata,
   output logic [`XENG_DATA_W-1:0]                   data_rdata
);

   logic [`XENG_DATA_W-1:0] status;

   // engine idle when every port is done
   assign status = {{(`XENG_DATA_W-1){1'b0}}, &done};

   // port registers only change on reads, so the selected word holds
   assign ctr_rdata  = ctr_is_status ? status : mem_a[rd_ctr_mem];
   assign data_rdata = mem_b[rd_dat_mem];

endmodule

//--- src/xeng_top.sv
`include "xeng_config.svh"

module xeng_top (
   input  logic                          rst,
   input  logic                          clk,
   input  logic                          ctr_valid,
   input  logic                          ctr_we,
   input  logic [`XENG_CTR_ADDR_W-1:0]   ctr_addr,
   input  logic [`XENG_DATA_W-1:0]       ctr_wdata,
   input  logic                          data_valid,
   input  logic                          data_we,
   input  logic [`XENG_DATA_ADDR_W-1:0]  data_addr,
   input  logic [`XENG_DATA_W-1:0]       data_wdata,
   input  xeng_pkg::engine_cfg_t         config_bus,
   output logic [`XENG_DATA_W-1:0]       ctr_rdata,
   output logic [`XENG_DATA_W-1:0]       data_rdata
);

   xeng_pkg::bus_t                            bus;
   xeng_pkg::engine_cfg_t                     cfg;
   logic                                      run_start;
   logic                                      ctr_is_status;
   logic [`XENG_MEM_SEL_W-1:0]                rd_ctr_mem;
   logic [`XENG_MEM_SEL_W-1:0]                rd_dat_mem;
   logic [`XENG_N_MEM-1:0][`XENG_DATA_W-1:0]  mem_a;
   logic [`XENG_N_MEM-1:0][`XENG_DATA_W-1:0]  mem_b;
   logic [2*`XENG_N_MEM-1:0]                  done;
   logic [`XENG_N_ALU-1:0][`XENG_DATA_W-1:0]  alu_out;
   logic [`XENG_N_MUL-1:0][`XENG_DATA_W-1:0]  mul_out;

   xeng_host_if ctr_mem [`XENG_N_MEM] ();
   xeng_host_if dat_mem [`XENG_N_MEM] ();

   // constant sources
   assign bus[`XENG_SRC_ZERO] = '0;
   assign bus[`XENG_SRC_ONE]  = `XENG_DATA_W'(1);

   xeng_host_decode u_decode (
      .rst(rst), .clk(clk),
      .ctr_valid(ctr_valid), .ctr_we(ctr_we),
      .ctr_addr(ctr_addr), .ctr_wdata(ctr_wdata),
      .data_valid(data_valid), .data_we(data_we),
      .data_addr(data_addr), .data_wdata(data_wdata),
      .config_bus(config_bus),
      .ctr_mem(ctr_mem), .dat_mem(dat_mem),
      .run_start(run_start), .cfg(cfg),
      .ctr_is_status(ctr_is_status),
      .rd_ctr_mem(rd_ctr_mem), .rd_dat_mem(rd_dat_mem)
   );

   for (genvar m = 0; m < `XENG_N_MEM; m++) begin : g_mem
      assign bus[`XENG_SRC_MEM0A + 2*m]     = mem_a[m];
      assign bus[`XENG_SRC_MEM0A + 2*m + 1] = mem_b[m];

      xeng_mem u_mem (
         .rst(rst), .clk(clk),
         .ctr_port(ctr_mem[m]), .dat_port(dat_mem[m]),
         .run_start(run_start),
         .cfg_a(cfg.mem[2*m]), .cfg_b(cfg.mem[2*m+1]),
         .bus(bus),
         .out_a(mem_a[m]), .out_b(mem_b[m]),
         .done_a(done[2*m]), .done_b(done[2*m+1])
      );
   end

   for (genvar i = 0; i < `XENG_N_ALU; i++) begin : g_alu
      assign bus[`XENG_SRC_ALU0 + i] = alu_out[i];

      xeng_alu u_alu (
         .rst(rst), .clk(clk), .run_start(run_start),
         .cfg(cfg.alu[i]), .bus(bus), .out(alu_out[i])
      );
   end

   for (genvar i = 0; i < `XENG_N_MUL; i++) begin : g_mul
      assign bus[`XENG_SRC_MUL0 + i] = mul_out[i];

      xeng_mul u_mul (
         .rst(rst), .clk(clk), .run_start(run_start),
         .cfg(cfg.mul[i]), .bus(bus), .out(mul_out[i])
      );
   end

   xeng_read_mux u_read_mux (
      .ctr_is_status(ctr_is_status),
      .rd_ctr_mem(rd_ctr_mem), .rd_dat_mem(rd_dat_mem),
      .mem_a(mem_a), .mem_b(mem_b), .done(done),
      .ctr_rdata(ctr_rdata), .data_rdata(data_rdata)
   );

endmodule

//--- verilog.f
+incdir+include
src/xeng_pkg.sv
src/xeng_host_if.sv
src/xeng_host_decode.sv
src/xeng_mem.sv
src/xeng_alu.sv
src/xeng_mul.sv
src/xeng_read_mux.sv
src/xeng_top.sv
bench/xeng_tb.sv
